/* hdl/demosaicPkg.sv */
`default_nettype none

package demosaicPkg;

	// Register stages between the window and the interpolated green
	localparam int interpSteps = 4;

	// Bayer site codes as {row parity, column parity}
	// Even rows run G B G B ..., odd rows R G R G ...
	localparam logic [1:0] siteGreenEven = 2'b00;
	localparam logic [1:0] siteBlue = 2'b01;
	localparam logic [1:0] siteRed = 2'b10;
	localparam logic [1:0] siteGreenOdd = 2'b11;

endpackage

`default_nettype wire

/* hdl/pixelIntake.sv */
`default_nettype none

module pixelIntake
	import demosaicPkg::*;
#(
	parameter int frameWidth = 1920,
	parameter int frameHeight = 1080,
	parameter int pixelWidth = 8
) (
	input logic clk,
	input logic reset,
	input logic pixReq,
	input logic [pixelWidth-1:0] pixData,
	input logic stall,
	output logic pixAck,
	output logic step,
	output logic [pixelWidth-1:0] stepPixel
);

	localparam int framePixels = frameWidth * frameHeight;
	// Enough zeros to push the last centre through window and interpolation
	localparam int flushSteps = frameWidth + 1 + interpSteps + 1;
	localparam int countWidth = $clog2(framePixels);
	localparam int flushWidth = $clog2(flushSteps);

	logic [countWidth-1:0] pixCount;
	logic [flushWidth-1:0] flushCount;
	logic flushing;
	logic acceptNow;
	logic flushNow;

	// New request seen, previous handshake closed
	assign acceptNow = pixReq && !pixAck && !flushing && !stall;
	assign flushNow = flushing && !stall;

	assign step = acceptNow || flushNow;
	assign stepPixel = flushing ? '0 : pixData;

	always_ff @(posedge clk) begin
		if (reset) begin
			pixAck <= 1'b0;
			pixCount <= '0;
			flushing <= 1'b0;
			flushCount <= '0;
		end else begin
			if (acceptNow) begin
				pixAck <= 1'b1;
				if (pixCount == countWidth'(framePixels - 1)) begin
					flushing <= 1'b1;
				end else begin
					pixCount <= pixCount + 1'b1;
				end
			end else if (pixAck && !pixReq) begin
				pixAck <= 1'b0;
			end

			// Zero run after the last pixel, then back to pixel zero
			if (flushNow) begin
				if (flushCount == flushWidth'(flushSteps - 1)) begin
					flushCount <= '0;
					flushing <= 1'b0;
					pixCount <= '0;
				end else begin
					flushCount <= flushCount + 1'b1;
				end
			end
		end
	end

	// Request is still up when the ack appears
	pixAckNeedsReq: assert property (@(posedge clk) disable iff (reset)
		$rose(pixAck) |-> pixReq);

endmodule

`default_nettype wire

/* hdl/lineWindow.sv */
`default_nettype none

module lineWindow
	import demosaicPkg::*;
#(
	parameter int frameWidth = 1920,
	parameter int frameHeight = 1080,
	parameter int pixelWidth = 8
) (
	input logic clk,
	input logic reset,
	input logic step,
	input logic [pixelWidth-1:0] stepPixel,
	output logic [pixelWidth-1:0] centre,
	output logic [pixelWidth-1:0] left,
	output logic [pixelWidth-1:0] right,
	output logic [pixelWidth-1:0] up,
	output logic [pixelWidth-1:0] down,
	output logic [$clog2(frameWidth)-1:0] centreX,
	output logic [$clog2(frameHeight)-1:0] centreY,
	output logic centreValid
);

	localparam int xWidth = $clog2(frameWidth);
	localparam int framePixels = frameWidth * frameHeight;
	// Pushes per frame, flush zeros included
	localparam int framePushes = framePixels + frameWidth + 1 + interpSteps + 1;
	localparam int pushWidth = $clog2(framePushes);

	// One row back and two rows back
	logic [pixelWidth-1:0] lineNear [frameWidth];
	logic [pixelWidth-1:0] lineFar [frameWidth];
	logic [xWidth-1:0] col;
	logic [pushWidth-1:0] pushCount;
	logic [pixelWidth-1:0] nearTap;
	logic [pixelWidth-1:0] farTap;
	logic [pixelWidth-1:0] upPre;
	logic [pixelWidth-1:0] downPre;
	logic validNext;

	assign nearTap = lineNear[col];
	assign farTap = lineFar[col];

	// Centre lags the push by one row plus one pixel
	assign validNext = (pushCount >= pushWidth'(frameWidth + 1)) &&
		(pushCount <= pushWidth'(framePixels + frameWidth));

	always_ff @(posedge clk) begin
		if (step) begin
			lineNear[col] <= stepPixel;
			lineFar[col] <= nearTap;
			// Middle row, three taps
			right <= nearTap;
			centre <= right;
			left <= centre;
			// Outer rows only need the centre column
			upPre <= farTap;
			up <= upPre;
			downPre <= stepPixel;
			down <= downPre;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			col <= '0;
			pushCount <= '0;
			centreValid <= 1'b0;
			centreX <= '0;
			centreY <= '0;
		end else if (step) begin
			if (col == xWidth'(frameWidth - 1)) begin
				col <= '0;
			end else begin
				col <= col + 1'b1;
			end

			if (pushCount == pushWidth'(framePushes - 1)) begin
				pushCount <= '0;
			end else begin
				pushCount <= pushCount + 1'b1;
			end

			centreValid <= validNext;
			if (!validNext || !centreValid) begin
				centreX <= '0;
				centreY <= '0;
			end else if (centreX == xWidth'(frameWidth - 1)) begin
				centreX <= '0;
				centreY <= centreY + 1'b1;
			end else begin
				centreX <= centreX + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/greenInterp.sv */
`default_nettype none

module greenInterp
	import demosaicPkg::*;
#(
	parameter int frameWidth = 1920,
	parameter int frameHeight = 1080,
	parameter int pixelWidth = 8
) (
	input logic clk,
	input logic reset,
	input logic step,
	input logic [pixelWidth-1:0] centre,
	input logic [pixelWidth-1:0] left,
	input logic [pixelWidth-1:0] right,
	input logic [pixelWidth-1:0] up,
	input logic [pixelWidth-1:0] down,
	input logic [$clog2(frameWidth)-1:0] centreX,
	input logic [$clog2(frameHeight)-1:0] centreY,
	input logic centreValid,
	output logic [pixelWidth-1:0] greenOut,
	output logic [pixelWidth-1:0] centreOut,
	output logic [1:0] siteOut,
	output logic lastOut,
	output logic resultValid
);

	localparam int xWidth = $clog2(frameWidth);
	localparam int yWidth = $clog2(frameHeight);

	function automatic logic [pixelWidth-1:0] absDiff(
		input logic [pixelWidth-1:0] a,
		input logic [pixelWidth-1:0] b
	);
		return (a > b) ? a - b : b - a;
	endfunction

	function automatic logic [pixelWidth-1:0] avgFloor(
		input logic [pixelWidth-1:0] a,
		input logic [pixelWidth-1:0] b
	);
		logic [pixelWidth:0] sum;
		sum = {1'b0, a} + {1'b0, b};
		return sum[pixelWidth:1];
	endfunction

	logic atLeft;
	logic atRight;
	logic atTop;
	logic atBottom;
	logic [pixelWidth-1:0] leftIn;
	logic [pixelWidth-1:0] rightIn;
	logic [pixelWidth-1:0] upIn;
	logic [pixelWidth-1:0] downIn;

	// Index is the step that last wrote the value, minus one
	logic [pixelWidth-1:0] hGrad [3];
	logic [pixelWidth-1:0] vGrad [3];
	logic [pixelWidth-1:0] gH [3];
	logic [pixelWidth-1:0] gV [3];
	logic [pixelWidth-1:0] gHV;

	logic [pixelWidth-1:0] centreDly [interpSteps];
	logic [1:0] siteDly [interpSteps];
	logic lastDly [interpSteps];
	logic validDly [interpSteps];

	assign atLeft = centreX == '0;
	assign atRight = centreX == xWidth'(frameWidth - 1);
	assign atTop = centreY == '0;
	assign atBottom = centreY == yWidth'(frameHeight - 1);

	// Out-of-frame neighbours count as zero
	assign leftIn = atLeft ? '0 : left;
	assign rightIn = atRight ? '0 : right;
	assign upIn = atTop ? '0 : up;
	assign downIn = atBottom ? '0 : down;

	always_ff @(posedge clk) begin
		if (step) begin
			// Step 1
			hGrad[0] <= absDiff(leftIn, rightIn);
			vGrad[0] <= absDiff(upIn, downIn);
			gH[0] <= atLeft ? rightIn : (atRight ? leftIn : avgFloor(leftIn, rightIn));
			gV[0] <= atTop ? downIn : (atBottom ? upIn : avgFloor(upIn, downIn));

			// Steps 2 and 3
			for (int i = 1; i < 3; i++) begin
				hGrad[i] <= hGrad[i-1];
				vGrad[i] <= vGrad[i-1];
				gH[i] <= gH[i-1];
				gV[i] <= gV[i-1];
			end
			gHV <= avgFloor(gH[1], gV[1]);

			// Step 4, follow the smoother direction
			if (hGrad[2] > vGrad[2]) begin
				greenOut <= gV[2];
			end else if (hGrad[2] < vGrad[2]) begin
				greenOut <= gH[2];
			end else begin
				greenOut <= gHV;
			end
		end
	end

	// Side band rides along with the arithmetic
	always_ff @(posedge clk) begin
		if (step) begin
			centreDly[0] <= centre;
			siteDly[0] <= {centreY[0], centreX[0]};
			lastDly[0] <= atRight && atBottom;
			for (int i = 1; i < interpSteps; i++) begin
				centreDly[i] <= centreDly[i-1];
				siteDly[i] <= siteDly[i-1];
				lastDly[i] <= lastDly[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < interpSteps; i++) begin
				validDly[i] <= 1'b0;
			end
		end else if (step) begin
			validDly[0] <= centreValid;
			for (int i = 1; i < interpSteps; i++) begin
				validDly[i] <= validDly[i-1];
			end
		end
	end

	assign centreOut = centreDly[interpSteps-1];
	assign siteOut = siteDly[interpSteps-1];
	assign lastOut = lastDly[interpSteps-1];
	assign resultValid = validDly[interpSteps-1];

endmodule

`default_nettype wire

/* hdl/rgbAssembler.sv */
`default_nettype none

module rgbAssembler
	import demosaicPkg::*;
#(
	parameter int frameWidth = 1920,
	parameter int frameHeight = 1080,
	parameter int pixelWidth = 8
) (
	input logic clk,
	input logic reset,
	input logic step,
	input logic [pixelWidth-1:0] greenOut,
	input logic [pixelWidth-1:0] centreOut,
	input logic [1:0] siteOut,
	input logic lastOut,
	input logic resultValid,
	input logic outAck,
	output logic outReq,
	output logic [pixelWidth-1:0] outR,
	output logic [pixelWidth-1:0] outG,
	output logic [pixelWidth-1:0] outB,
	output logic [$clog2(frameWidth)-1:0] outX,
	output logic [$clog2(frameHeight)-1:0] outY,
	output logic outLast,
	output logic stall
);

	localparam int xWidth = $clog2(frameWidth);
	localparam int yWidth = $clog2(frameHeight);

	logic [xWidth-1:0] xCount;
	logic [yWidth-1:0] yCount;
	logic capture;

	// Result left by the previous step is taken on this one
	assign capture = step && resultValid;
	assign stall = outReq || outAck;

	always_ff @(posedge clk) begin
		if (capture) begin
			outX <= xCount;
			outY <= yCount;
			outLast <= lastOut;
			case (siteOut)
				siteGreenEven, siteGreenOdd: begin
					outR <= '0;
					outG <= centreOut;
					outB <= '0;
				end
				siteBlue: begin
					outR <= '0;
					outG <= greenOut;
					outB <= centreOut;
				end
				siteRed: begin
					outR <= centreOut;
					outG <= greenOut;
					outB <= '0;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			outReq <= 1'b0;
			xCount <= '0;
			yCount <= '0;
		end else begin
			if (capture) begin
				outReq <= 1'b1;
				// Restart the raster after the frame's last pixel
				if (lastOut) begin
					xCount <= '0;
					yCount <= '0;
				end else if (xCount == xWidth'(frameWidth - 1)) begin
					xCount <= '0;
					yCount <= yCount + 1'b1;
				end else begin
					xCount <= xCount + 1'b1;
				end
			end else if (outReq && outAck) begin
				outReq <= 1'b0;
			end
		end
	end

	outHoldsWhileWaiting: assert property (@(posedge clk) disable iff (reset)
		(outReq && !outAck) |=> $stable({outR, outG, outB, outX, outY, outLast}));

	// Intake must stay frozen until the sink has released ack
	noReqDuringAck: assert property (@(posedge clk) disable iff (reset)
		$rose(outReq) |-> !$past(outAck));

endmodule

`default_nettype wire

/* hdl/demosaicTop.sv */
`default_nettype none

module demosaicTop #(
	parameter int frameWidth = 1920,
	parameter int frameHeight = 1080,
	parameter int pixelWidth = 8
) (
	input logic clk,
	input logic reset,
	input logic pixReq,
	input logic [pixelWidth-1:0] pixData,
	output logic pixAck,
	output logic outReq,
	output logic [pixelWidth-1:0] outR,
	output logic [pixelWidth-1:0] outG,
	output logic [pixelWidth-1:0] outB,
	output logic [$clog2(frameWidth)-1:0] outX,
	output logic [$clog2(frameHeight)-1:0] outY,
	output logic outLast,
	input logic outAck
);

	localparam int xWidth = $clog2(frameWidth);
	localparam int yWidth = $clog2(frameHeight);

	logic step;
	logic [pixelWidth-1:0] stepPixel;
	logic stall;

	// Window taps
	logic [pixelWidth-1:0] centre;
	logic [pixelWidth-1:0] left;
	logic [pixelWidth-1:0] right;
	logic [pixelWidth-1:0] up;
	logic [pixelWidth-1:0] down;
	logic [xWidth-1:0] centreX;
	logic [yWidth-1:0] centreY;
	logic centreValid;

	// Interpolated result
	logic [pixelWidth-1:0] greenOut;
	logic [pixelWidth-1:0] centreOut;
	logic [1:0] siteOut;
	logic lastOut;
	logic resultValid;

	pixelIntake #(
		.frameWidth(frameWidth),
		.frameHeight(frameHeight),
		.pixelWidth(pixelWidth)
	) intake_i (
		.clk(clk),
		.reset(reset),
		.pixReq(pixReq),
		.pixData(pixData),
		.stall(stall),
		.pixAck(pixAck),
		.step(step),
		.stepPixel(stepPixel)
	);

	lineWindow #(
		.frameWidth(frameWidth),
		.frameHeight(frameHeight),
		.pixelWidth(pixelWidth)
	) window_i (
		.clk(clk),
		.reset(reset),
		.step(step),
		.stepPixel(stepPixel),
		.centre(centre),
		.left(left),
		.right(right),
		.up(up),
		.down(down),
		.centreX(centreX),
		.centreY(centreY),
		.centreValid(centreValid)
	);

	greenInterp #(
		.frameWidth(frameWidth),
		.frameHeight(frameHeight),
		.pixelWidth(pixelWidth)
	) interp_i (
		.clk(clk),
		.reset(reset),
		.step(step),
		.centre(centre),
		.left(left),
		.right(right),
		.up(up),
		.down(down),
		.centreX(centreX),
		.centreY(centreY),
		.centreValid(centreValid),
		.greenOut(greenOut),
		.centreOut(centreOut),
		.siteOut(siteOut),
		.lastOut(lastOut),
		.resultValid(resultValid)
	);

	rgbAssembler #(
		.frameWidth(frameWidth),
		.frameHeight(frameHeight),
		.pixelWidth(pixelWidth)
	) assembler_i (
		.clk(clk),
		.reset(reset),
		.step(step),
		.greenOut(greenOut),
		.centreOut(centreOut),
		.siteOut(siteOut),
		.lastOut(lastOut),
		.resultValid(resultValid),
		.outAck(outAck),
		.outReq(outReq),
		.outR(outR),
		.outG(outG),
		.outB(outB),
		.outX(outX),
		.outY(outY),
		.outLast(outLast),
		.stall(stall)
	);

endmodule

`default_nettype wire

/* verif/tbClock.sv */
`default_nettype none

module tbClock #(
	parameter int periodNs = 20
) (
	output logic clk
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #(periodNs / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

/* verif/demosaicChecker.sv */
`default_nettype none

module demosaicChecker #(
	parameter int frameWidth = 8,
	parameter int frameHeight = 6,
	parameter int pixelWidth = 8,
	parameter int numFrames = 3
) (
	input logic clk,
	input logic reset,
	input logic [pixelWidth-1:0] pixData,
	input logic pixAck,
	input logic outReq,
	input logic outAck,
	input logic [pixelWidth-1:0] outR,
	input logic [pixelWidth-1:0] outG,
	input logic [pixelWidth-1:0] outB,
	input logic [$clog2(frameWidth)-1:0] outX,
	input logic [$clog2(frameHeight)-1:0] outY,
	input logic outLast,
	input logic runDone,
	output int errorCount,
	output int framesChecked
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int framePixels = frameWidth * frameHeight;
	localparam int totalPixels = numFrames * framePixels;

	// Every pixel sent so far, frames back to back
	int inPix [totalPixels];
	int inCount;
	int outCount;
	int frameErrors;
	int greenSites;
	int borderSites;
	logic ackSeen;
	logic reported;

	// Out-of-frame positions read as zero
	function automatic int pixelAt(input int base, input int x, input int y);
		if (x < 0 || x >= frameWidth || y < 0 || y >= frameHeight) begin
			return 0;
		end
		return inPix[base + y * frameWidth + x];
	endfunction

	function automatic int expectedGreen(input int base, input int x, input int y);
		int l;
		int r;
		int u;
		int d;
		int hGrad;
		int vGrad;
		int gH;
		int gV;
		l = pixelAt(base, x - 1, y);
		r = pixelAt(base, x + 1, y);
		u = pixelAt(base, x, y - 1);
		d = pixelAt(base, x, y + 1);
		hGrad = (l > r) ? l - r : r - l;
		vGrad = (u > d) ? u - d : d - u;
		// On a border only the inner neighbour counts
		gH = (x == 0) ? r : ((x == frameWidth - 1) ? l : (l + r) / 2);
		gV = (y == 0) ? d : ((y == frameHeight - 1) ? u : (u + d) / 2);
		if (hGrad > vGrad) begin
			return gV;
		end else if (hGrad < vGrad) begin
			return gH;
		end
		return (gH + gV) / 2;
	endfunction

	task automatic compareField(input string name, input int got, input int expected,
		input int frame, input int x, input int y);
		if (got != expected) begin
			$display("FAILED at %0t: frame %0d pixel (%0d,%0d) %s is %0d, expected %0d",
				$time, frame, x, y, name, got, expected);
			errorCount++;
			frameErrors++;
		end
	endtask

	task automatic checkOutput();
		int frame;
		int idx;
		int x;
		int y;
		int base;
		int centre;
		int expR;
		int expG;
		int expB;
		if (outCount >= totalPixels) begin
			$display("Unexpected output at %0t after all frames were checked", $time);
			errorCount++;
			return;
		end
		frame = outCount / framePixels;
		idx = outCount % framePixels;
		x = idx % frameWidth;
		y = idx / frameWidth;
		base = frame * framePixels;
		if (inCount <= base + idx) begin
			$display("Output at %0t for pixel %0d came before that pixel was sent",
				$time, outCount);
			errorCount++;
		end
		centre = pixelAt(base, x, y);
		// Even rows run G B G B, odd rows R G R G
		if ((x % 2) == (y % 2)) begin
			expR = 0;
			expG = centre;
			expB = 0;
			greenSites++;
		end else begin
			expG = expectedGreen(base, x, y);
			expR = (y % 2 == 1) ? centre : 0;
			expB = (y % 2 == 0) ? centre : 0;
			if (x == 0 || y == 0 || x == frameWidth - 1 || y == frameHeight - 1) begin
				borderSites++;
			end
		end
		compareField("outX", int'(outX), x, frame, x, y);
		compareField("outY", int'(outY), y, frame, x, y);
		compareField("outR", int'(outR), expR, frame, x, y);
		compareField("outG", int'(outG), expG, frame, x, y);
		compareField("outB", int'(outB), expB, frame, x, y);
		compareField("outLast", int'(outLast), (idx == framePixels - 1) ? 1 : 0, frame, x, y);
		outCount++;
		if (idx == framePixels - 1) begin
			$display("Frame %0d done: %0d pixels, %0d green, %0d red/blue on border, %0d errors",
				frame, framePixels, greenSites, borderSites, frameErrors);
			framesChecked++;
			frameErrors = 0;
			greenSites = 0;
			borderSites = 0;
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			inCount = 0;
			outCount = 0;
			errorCount = 0;
			framesChecked = 0;
			frameErrors = 0;
			greenSites = 0;
			borderSites = 0;
			ackSeen = 1'b0;
			reported = 1'b0;
		end else begin
			// Data is still held on the edge where ack is first seen
			if (pixAck && !ackSeen && inCount < totalPixels) begin
				inPix[inCount] = int'(pixData);
				inCount++;
			end
			ackSeen = pixAck;
			if (outReq && outAck) begin
				checkOutput();
			end
			if (runDone && !reported) begin
				$display("Totals: %0d pixels in, %0d pixels out, %0d frames, %0d errors",
					inCount, outCount, framesChecked, errorCount);
				reported = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* verif/demosaicTb.sv */
`default_nettype none

module demosaicTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int frameWidth = 8;
	localparam int frameHeight = 6;
	localparam int pixelWidth = 8;
	localparam int numFrames = 3;
	localparam int resetCycles = 10;
	localparam int idleCycles = 20;
	localparam int framePixels = frameWidth * frameHeight;
	localparam int flushSteps = frameWidth + 1 + demosaicPkg::interpSteps + 1;
	// About 20 cycles per step covers gaps, both handshakes and ack delays
	localparam int cycleLimit = numFrames * (framePixels + flushSteps) * 20 +
		resetCycles + 2 * idleCycles;

	logic clk;
	logic reset;
	logic pixReq;
	logic [pixelWidth-1:0] pixData;
	logic pixAck;
	logic outReq;
	logic [pixelWidth-1:0] outR;
	logic [pixelWidth-1:0] outG;
	logic [pixelWidth-1:0] outB;
	logic [$clog2(frameWidth)-1:0] outX;
	logic [$clog2(frameHeight)-1:0] outY;
	logic outLast;
	logic outAck;
	logic runDone;
	int errorCount;
	int framesChecked;
	int resetErrors;
	int cycleCount = 0;

	tbClock #(
		.periodNs(20)
	) clock_i (
		.clk(clk)
	);

	demosaicTop #(
		.frameWidth(frameWidth),
		.frameHeight(frameHeight),
		.pixelWidth(pixelWidth)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.pixReq(pixReq),
		.pixData(pixData),
		.pixAck(pixAck),
		.outReq(outReq),
		.outR(outR),
		.outG(outG),
		.outB(outB),
		.outX(outX),
		.outY(outY),
		.outLast(outLast),
		.outAck(outAck)
	);

	demosaicChecker #(
		.frameWidth(frameWidth),
		.frameHeight(frameHeight),
		.pixelWidth(pixelWidth),
		.numFrames(numFrames)
	) check_i (
		.clk(clk),
		.reset(reset),
		.pixData(pixData),
		.pixAck(pixAck),
		.outReq(outReq),
		.outAck(outAck),
		.outR(outR),
		.outG(outG),
		.outB(outB),
		.outX(outX),
		.outY(outY),
		.outLast(outLast),
		.runDone(runDone),
		.errorCount(errorCount),
		.framesChecked(framesChecked)
	);

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: run not finished after %0d cycles", cycleLimit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// Four-phase source, random idle gap before each request
	task automatic sendPixel(input logic [pixelWidth-1:0] value);
		int gap;
		gap = $urandom_range(0, 3);
		repeat (gap) @(posedge clk);
		pixReq <= 1'b1;
		pixData <= value;
		do begin
			@(posedge clk);
		end while (!pixAck);
		pixReq <= 1'b0;
		do begin
			@(posedge clk);
		end while (pixAck);
	endtask

	task automatic sendFrame(input int frameIndex);
		logic [pixelWidth-1:0] value;
		for (int i = 0; i < framePixels; i++) begin
			// Narrow range in frame 1 so equal gradients show up
			if (frameIndex == 1) begin
				value = pixelWidth'($urandom_range(0, 3));
			end else begin
				value = pixelWidth'($urandom);
			end
			sendPixel(value);
		end
	endtask

	task automatic runSink();
		int delay;
		outAck <= 1'b0;
		forever begin
			@(posedge clk);
			if (outReq && !outAck) begin
				delay = $urandom_range(0, 5);
				repeat (delay) @(posedge clk);
				outAck <= 1'b1;
				do begin
					@(posedge clk);
				end while (outReq);
				outAck <= 1'b0;
			end
		end
	endtask

	// Nothing may move while no pixel has been offered
	task automatic checkIdleAfterReset();
		int badCycles;
		badCycles = 0;
		repeat (idleCycles) begin
			@(posedge clk);
			if (pixAck || outReq) begin
				badCycles++;
			end
		end
		if (badCycles == 0) begin
			$display("Reset test done: pixAck and outReq low for %0d idle cycles", idleCycles);
		end else begin
			$display("FAILED at %0t: pixAck or outReq high on %0d idle cycles after reset",
				$time, badCycles);
			resetErrors++;
		end
	endtask

	initial begin
		void'($urandom(32'h4b99_3b80));
		reset <= 1'b1;
		pixReq <= 1'b0;
		pixData <= '0;
		runDone <= 1'b0;
		resetErrors = 0;
		fork
			runSink();
		join_none
		repeat (resetCycles) @(posedge clk);
		reset <= 1'b0;
		checkIdleAfterReset();
		for (int f = 0; f < numFrames; f++) begin
			sendFrame(f);
		end
		wait (framesChecked == numFrames);
		// Extra cycles let a stray output show up
		repeat (idleCycles) @(posedge clk);
		runDone <= 1'b1;
		@(posedge clk);
		// Counts are settled between edges
		@(negedge clk);
		if (errorCount == 0 && resetErrors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
hdl/demosaicPkg.sv
hdl/pixelIntake.sv
hdl/lineWindow.sv
hdl/greenInterp.sv
hdl/rgbAssembler.sv
hdl/demosaicTop.sv
verif/tbClock.sv
verif/demosaicChecker.sv
verif/demosaicTb.sv

/* Makefile */
TOP = demosaicTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f build.f -Mdir obj_dir -o demosaicSim
	@out="$$(./obj_dir/demosaicSim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir
